// ==== mul_params.svh ====
// Shared multiply unit parameters
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Operand and result width.
`define MUL_XLEN 64

// Number of hart request ports.
`define MUL_PORTS 2

// Width of a port index.
`define MUL_PORT_W 1

`endif

// ==== rv_mul_pkg.sv ====
// RISC-V multiply types
package rv_mul_pkg;

    // M-extension multiply operations.
    typedef enum logic [2:0] {
        MUL    = 3'd0, // Low half, sign agnostic.
        MULH   = 3'd1, // High half, signed x signed.
        MULHSU = 3'd2, // High half, signed x unsigned.
        MULHU  = 3'd3, // High half, unsigned x unsigned.
        MULW   = 3'd4  // Low word, sign-extended.
    } mul_op_e;

    // How the two operands are interpreted.
    typedef enum logic [1:0] {
        SIGN_SS = 2'd0,
        SIGN_SU = 2'd1,
        SIGN_UU = 2'd2
    } sign_mode_e;

endpackage

// ==== mul_ctrl_pkg.sv ====
// Multiply unit control types
`include "mul_params.svh"

package mul_ctrl_pkg;

    // Request port FSM.
    typedef enum logic [1:0] {
        EMPTY     = 2'd0,
        WAIT_DONE = 2'd1,
        HOLD_RESP = 2'd2
    } port_state_e;

    // Multiplier core FSM.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } core_state_e;

    typedef logic [`MUL_PORT_W-1:0] port_idx_t;

endpackage

// ==== mul_result_format.sv ====
// Multiply result formatting
`include "mul_params.svh"

module mul_result_format (
    input  rv_mul_pkg::mul_op_e       op,
    input  logic                      neg,
    input  logic [2*`MUL_XLEN-1:0]    mag,
    output logic [`MUL_XLEN-1:0]      result
);

    localparam int XLEN = `MUL_XLEN;
    localparam int HALF = `MUL_XLEN / 2;

    logic [2*XLEN-1:0] prod;

    // Two's complement of the full product restores the sign.
    assign prod = neg ? -mag : mag;

    always_comb begin
        unique case (op)
            rv_mul_pkg::MULH,
            rv_mul_pkg::MULHSU,
            rv_mul_pkg::MULHU:
                result = prod[2*XLEN-1:XLEN];
            rv_mul_pkg::MULW:
                result = {{HALF{prod[HALF-1]}}, prod[HALF-1:0]};
            default:
                result = prod[XLEN-1:0]; // MUL.
        endcase
    end

endmodule

// ==== mul_req_port.sv ====
// Hart request port
`include "mul_params.svh"

module mul_req_port (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  rv_mul_pkg::mul_op_e     req_op,
    input  logic [`MUL_XLEN-1:0]    req_a,
    input  logic [`MUL_XLEN-1:0]    req_b,
    output logic                    pend,
    output rv_mul_pkg::mul_op_e     pend_op,
    output logic [`MUL_XLEN-1:0]    pend_a,
    output logic [`MUL_XLEN-1:0]    pend_b,
    input  logic                    done,
    input  logic [`MUL_XLEN-1:0]    result,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output logic [`MUL_XLEN-1:0]    resp_data
);

    mul_ctrl_pkg::port_state_e state;

    assign req_ready  = (state == mul_ctrl_pkg::EMPTY);
    assign pend       = (state == mul_ctrl_pkg::WAIT_DONE);
    assign resp_valid = (state == mul_ctrl_pkg::HOLD_RESP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mul_ctrl_pkg::EMPTY;
        end else begin
            unique case (state)
                mul_ctrl_pkg::EMPTY:
                    if (req_valid) state <= mul_ctrl_pkg::WAIT_DONE;
                mul_ctrl_pkg::WAIT_DONE:
                    if (done) state <= mul_ctrl_pkg::HOLD_RESP;
                mul_ctrl_pkg::HOLD_RESP:
                    if (resp_ready) state <= mul_ctrl_pkg::EMPTY;
                default:
                    state <= mul_ctrl_pkg::EMPTY;
            endcase
        end
    end

    // Request held steady until the core finishes with it.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            pend_op <= req_op;
            pend_a  <= req_a;
            pend_b  <= req_b;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_data <= result; // Kept until the hart takes it.
        end
    end

    a_resp_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> $stable(resp_data)
    ) else $error("resp_data changed under back-pressure");

endmodule

// ==== mul_arbiter.sv ====
// Round-robin arbiter for the multiplier core
`include "mul_params.svh"

module mul_arbiter (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic [`MUL_PORTS-1:0]                      pend,
    input  rv_mul_pkg::mul_op_e [`MUL_PORTS-1:0]       pend_op,
    input  logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]       pend_a,
    input  logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]       pend_b,
    output logic                                       start,
    output rv_mul_pkg::mul_op_e                        start_op,
    output logic [`MUL_XLEN-1:0]                       start_a,
    output logic [`MUL_XLEN-1:0]                       start_b,
    input  logic                                       core_busy,
    input  logic                                       core_done,
    input  logic [`MUL_XLEN-1:0]                       core_result,
    output logic [`MUL_PORTS-1:0]                      port_done,
    output logic [`MUL_XLEN-1:0]                       port_result
);

    mul_ctrl_pkg::port_idx_t rr_ptr;    // Last port served.
    mul_ctrl_pkg::port_idx_t grant_idx;
    mul_ctrl_pkg::port_idx_t pick_idx;
    logic                    grant_vld;
    logic                    pick_vld;

    // Search from the port after rr_ptr; the nearest pending one wins.
    always_comb begin
        pick_vld = 1'b0;
        pick_idx = rr_ptr;
        for (int i = `MUL_PORTS; i >= 1; i--) begin
            if (pend[(int'(rr_ptr) + i) % `MUL_PORTS]) begin
                pick_vld = 1'b1;
                pick_idx = mul_ctrl_pkg::port_idx_t'((int'(rr_ptr) + i) % `MUL_PORTS);
            end
        end
    end

    assign start    = pick_vld && !grant_vld;
    assign start_op = pend_op[pick_idx];
    assign start_a  = pend_a[pick_idx];
    assign start_b  = pend_b[pick_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_vld <= 1'b0;
            grant_idx <= '0;
            rr_ptr    <= mul_ctrl_pkg::port_idx_t'(`MUL_PORTS - 1);
        end else if (start) begin
            grant_vld <= 1'b1;
            grant_idx <= pick_idx;
        end else if (core_done) begin
            grant_vld <= 1'b0;
            rr_ptr    <= grant_idx; // Pointer advances when the grant retires.
        end
    end

    always_comb begin
        port_done = '0;
        port_done[grant_idx] = core_done && grant_vld;
    end

    assign port_result = core_result;

    a_done_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) core_done |-> $onehot(port_done & pend)
    ) else $error("core done not routed to exactly one waiting port");

    // Grant tracking must agree with the core's own view of busy.
    a_start_idle: assert property (
        @(posedge clk) disable iff (!arst_n) start |-> !core_busy
    ) else $error("start issued while core busy");

endmodule

// ==== mul_core.sv ====
// Iterative shift-add multiplier core
`include "mul_params.svh"

module mul_core (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  rv_mul_pkg::mul_op_e     op,
    input  logic [`MUL_XLEN-1:0]    a,
    input  logic [`MUL_XLEN-1:0]    b,
    output logic                    busy,
    output logic                    done,
    output logic [`MUL_XLEN-1:0]    result
);

    localparam int XLEN = `MUL_XLEN;
    localparam int HALF = `MUL_XLEN / 2;

    mul_ctrl_pkg::core_state_e state;
    rv_mul_pkg::sign_mode_e    mode;

    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [2*XLEN-1:0] mcand;
    logic [XLEN-1:0]   mplier;
    logic [2*XLEN-1:0] acc;
    rv_mul_pkg::mul_op_e op_q;
    logic              neg_q;

    always_comb begin
        unique case (op)
            rv_mul_pkg::MULHSU: mode = rv_mul_pkg::SIGN_SU;
            rv_mul_pkg::MULHU:  mode = rv_mul_pkg::SIGN_UU;
            default:            mode = rv_mul_pkg::SIGN_SS;
        endcase
    end

    // Word ops see only the low halves, sign-extended.
    assign op_a = (op == rv_mul_pkg::MULW) ? {{HALF{a[HALF-1]}}, a[HALF-1:0]} : a;
    assign op_b = (op == rv_mul_pkg::MULW) ? {{HALF{b[HALF-1]}}, b[HALF-1:0]} : b;

    assign a_neg = (mode != rv_mul_pkg::SIGN_UU) && op_a[XLEN-1];
    assign b_neg = (mode == rv_mul_pkg::SIGN_SS) && op_b[XLEN-1];
    assign a_mag = a_neg ? -op_a : op_a;
    assign b_mag = b_neg ? -op_b : op_b;

    assign busy = (state != mul_ctrl_pkg::IDLE);
    assign done = (state == mul_ctrl_pkg::DONE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mul_ctrl_pkg::IDLE;
        end else begin
            unique case (state)
                mul_ctrl_pkg::IDLE:
                    if (start) begin
                        state <= (b_mag == '0) ? mul_ctrl_pkg::DONE : mul_ctrl_pkg::RUN;
                    end
                mul_ctrl_pkg::RUN:
                    if (mplier[XLEN-1:1] == '0) state <= mul_ctrl_pkg::DONE; // Early stop.
                mul_ctrl_pkg::DONE:
                    state <= mul_ctrl_pkg::IDLE;
                default:
                    state <= mul_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand  <= {{XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            acc    <= '0;
            op_q   <= op;
            neg_q  <= a_neg ^ b_neg; // Sign belongs to this operation only.
        end else if (state == mul_ctrl_pkg::RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    mul_result_format i_fmt (
        .op     (op_q),
        .neg    (neg_q),
        .mag    (acc),
        .result (result)
    );

endmodule

// ==== shared_mul_unit.sv ====
// Shared two-port multiply unit
`include "mul_params.svh"

module shared_mul_unit (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic [`MUL_PORTS-1:0]                  req_valid,
    output logic [`MUL_PORTS-1:0]                  req_ready,
    input  rv_mul_pkg::mul_op_e [`MUL_PORTS-1:0]   req_op,
    input  logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   req_a,
    input  logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   req_b,
    output logic [`MUL_PORTS-1:0]                  resp_valid,
    input  logic [`MUL_PORTS-1:0]                  resp_ready,
    output logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   resp_data
);

    localparam mul_ctrl_pkg::port_idx_t P0 = 0;
    localparam mul_ctrl_pkg::port_idx_t P1 = 1;

    logic [`MUL_PORTS-1:0]                  pend;
    rv_mul_pkg::mul_op_e [`MUL_PORTS-1:0]   pend_op;
    logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   pend_a;
    logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   pend_b;
    logic [`MUL_PORTS-1:0]                  port_done;
    logic [`MUL_XLEN-1:0]                   port_result;

    logic                   start;
    rv_mul_pkg::mul_op_e    start_op;
    logic [`MUL_XLEN-1:0]   start_a;
    logic [`MUL_XLEN-1:0]   start_b;
    logic                   core_busy;
    logic                   core_done;
    logic [`MUL_XLEN-1:0]   core_result;

    mul_req_port i_port0 (
        .clk (clk), .arst_n (arst_n),
        .req_valid  (req_valid[P0]),  .req_ready  (req_ready[P0]),
        .req_op     (req_op[P0]),     .req_a      (req_a[P0]),     .req_b (req_b[P0]),
        .pend       (pend[P0]),       .pend_op    (pend_op[P0]),
        .pend_a     (pend_a[P0]),     .pend_b     (pend_b[P0]),
        .done       (port_done[P0]),  .result     (port_result),
        .resp_valid (resp_valid[P0]), .resp_ready (resp_ready[P0]),
        .resp_data  (resp_data[P0])
    );

    mul_req_port i_port1 (
        .clk (clk), .arst_n (arst_n),
        .req_valid  (req_valid[P1]),  .req_ready  (req_ready[P1]),
        .req_op     (req_op[P1]),     .req_a      (req_a[P1]),     .req_b (req_b[P1]),
        .pend       (pend[P1]),       .pend_op    (pend_op[P1]),
        .pend_a     (pend_a[P1]),     .pend_b     (pend_b[P1]),
        .done       (port_done[P1]),  .result     (port_result),
        .resp_valid (resp_valid[P1]), .resp_ready (resp_ready[P1]),
        .resp_data  (resp_data[P1])
    );

    mul_arbiter i_arb (
        .clk (clk), .arst_n (arst_n),
        .pend      (pend),      .pend_op     (pend_op),
        .pend_a    (pend_a),    .pend_b      (pend_b),
        .start     (start),     .start_op    (start_op),
        .start_a   (start_a),   .start_b     (start_b),
        .core_busy (core_busy), .core_done   (core_done),
        .core_result (core_result),
        .port_done (port_done), .port_result (port_result)
    );

    mul_core i_core (
        .clk (clk), .arst_n (arst_n),
        .start  (start),     .op   (start_op),
        .a      (start_a),   .b    (start_b),
        .busy   (core_busy), .done (core_done),
        .result (core_result)
    );

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 arst_n = 1'b1; // Released just after an edge.
    end

endmodule

// ==== tb_shared_mul_unit.sv ====
// Shared multiply unit testbench
`include "mul_params.svh"

module tb_shared_mul_unit;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_ROWS    = 40;
    localparam int HOLD_CYCLES  = 400;
    localparam logic [`MUL_XLEN-1:0] MAXP = {1'b0, {(`MUL_XLEN-1){1'b1}}};
    localparam logic [`MUL_XLEN-1:0] MINN = {1'b1, {(`MUL_XLEN-1){1'b0}}};
    localparam logic [`MUL_XLEN-1:0] ONES = '1;

    logic clk;
    logic arst_n;
    logic [`MUL_PORTS-1:0]                  req_valid;
    logic [`MUL_PORTS-1:0]                  req_ready;
    rv_mul_pkg::mul_op_e [`MUL_PORTS-1:0]   req_op;
    logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   req_a;
    logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   req_b;
    logic [`MUL_PORTS-1:0]                  resp_valid;
    logic [`MUL_PORTS-1:0]                  resp_ready;
    logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0]   resp_data;

    // Stimulus table, one entry per test.
    string                 row_name[$];
    int                    row_port[$];
    rv_mul_pkg::mul_op_e   row_op[$];
    logic [`MUL_XLEN-1:0]  row_a[$];
    logic [`MUL_XLEN-1:0]  row_b[$];
    logic [`MUL_XLEN-1:0]  row_exp[$];

    int q0[$]; // Rows in flight on port 0.
    int q1[$];
    int n_first;
    int errors;
    int resp_count;
    int overlap;
    int last_port;
    int hold_cnt;
    logic stall_en;
    logic fair_en;
    logic table_ready;
    logic [31:0] lfsr;
    logic [`MUL_PORTS-1:0]                held;
    logic [`MUL_PORTS-1:0][`MUL_XLEN-1:0] held_data;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    shared_mul_unit i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_a      (req_a),
        .req_b      (req_b),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data)
    );

    // RISC-V result from full-width products.
    function automatic logic [`MUL_XLEN-1:0] ref_mul(input rv_mul_pkg::mul_op_e op,
                                                     input logic [`MUL_XLEN-1:0] a,
                                                     input logic [`MUL_XLEN-1:0] b);
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic [127:0]        ua;
        logic [127:0]        ub;
        logic [127:0]        p;
        logic signed [63:0]  w;
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        w  = $signed(a[31:0]) * $signed(b[31:0]);
        case (op)
            rv_mul_pkg::MULH:   p = sa * sb;
            rv_mul_pkg::MULHSU: p = sa * ub;
            rv_mul_pkg::MULHU:  p = ua * ub;
            default:            p = sa * sb;
        endcase
        if (op == rv_mul_pkg::MULW) return {{32{w[31]}}, w[31:0]};
        if (op == rv_mul_pkg::MUL) return p[63:0];
        return p[127:64];
    endfunction

    // Galois LFSR, one step per bit.
    function automatic logic step_lfsr();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[62:0], step_lfsr()};
        return v;
    endfunction

    task automatic add_row(input string name, input int port, input rv_mul_pkg::mul_op_e op,
                           input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
        row_name.push_back(name);
        row_port.push_back(port);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_exp.push_back(ref_mul(op, a, b));
    endtask

    task automatic build_table();
        logic [`MUL_XLEN-1:0] ca [10];
        logic [`MUL_XLEN-1:0] cb [10];
        logic [`MUL_XLEN-1:0] ra;
        logic [`MUL_XLEN-1:0] rb;
        rv_mul_pkg::mul_op_e  op;
        int                   port;
        ca = '{64'd0, 64'd1, ONES, MINN, MAXP, MINN, -64'd7, 64'd5, MAXP, 64'h1234_5678_9abc_def0};
        cb = '{ONES, ONES, ONES, MINN, MAXP, ONES, 64'd3, -64'd9, MINN, 64'hfedc_ba98_7654_3210};
        for (int o = 0; o < 5; o++) begin
            op = rv_mul_pkg::mul_op_e'(o);
            for (int k = 0; k < 10; k++) begin
                add_row($sformatf("corner_%s_%0d", op.name(), k), row_name.size() % 2, op,
                        ca[k], cb[k]);
            end
        end
        add_row("mulw_bit31", row_name.size() % 2, rv_mul_pkg::MULW, 64'h1_0000, 64'h8000);
        add_row("mulw_upper_ignored", row_name.size() % 2, rv_mul_pkg::MULW,
                64'hffff_ffff_4000_0000, 64'hdead_beef_0000_0002);
        // Small multipliers finish after a few core cycles.
        add_row("early_b0", row_name.size() % 2, rv_mul_pkg::MUL, -64'd7, 64'd0);
        add_row("early_b1", row_name.size() % 2, rv_mul_pkg::MUL, MAXP, 64'd1);
        add_row("early_b2", row_name.size() % 2, rv_mul_pkg::MULHU, ONES, 64'd2);
        add_row("early_neg1", row_name.size() % 2, rv_mul_pkg::MULH, MINN, ONES);
        add_row("early_b3", row_name.size() % 2, rv_mul_pkg::MULHSU, MINN, 64'd3);
        add_row("early_w0", row_name.size() % 2, rv_mul_pkg::MULW, 64'h7fff_ffff, 64'd0);
        n_first = row_name.size();
        for (int i = 0; i < RAND_ROWS; i++) begin
            port = int'(rand_bits(1));
            op   = rv_mul_pkg::mul_op_e'(int'(rand_bits(3)) % 5);
            ra   = rand_bits(64);
            rb   = rand_bits(64);
            add_row($sformatf("random_%0d", i), port, op, ra, rb);
        end
    endtask

    // Holds req_valid until each of the port's rows is accepted.
    task automatic issue_rows(input int p, input int first, input int last);
        for (int i = first; i < last; i++) begin
            if (row_port[i] == p) begin
                req_valid[p] = 1'b1;
                req_op[p]    = row_op[i];
                req_a[p]     = row_a[i];
                req_b[p]     = row_b[i];
                while (!req_ready[p]) begin
                    @(posedge clk);
                    #2;
                end
                @(posedge clk);
                if (p == 0) q0.push_back(i);
                else q1.push_back(i);
                #2;
            end
        end
        req_valid[p] = 1'b0;
    endtask

    task automatic check_resp(input int p);
        int idx;
        int qsize;
        resp_count++;
        qsize = (p == 0) ? q0.size() : q1.size();
        assert (qsize > 0) else begin
            errors++;
            $display("Port %0d returned a response with no request outstanding", p);
        end
        if (qsize > 0) begin
            if (p == 0) idx = q0.pop_front();
            else idx = q1.pop_front();
            assert (resp_data[p] == row_exp[idx]) else begin
                errors++;
                $display("Mismatch %s: expected %h, actual %h", row_name[idx], row_exp[idx],
                         resp_data[p]);
            end
            if (fair_en) begin
                assert (p != last_port) else begin
                    errors++;
                    $display("Port %0d was served twice in a row with both ports waiting", p);
                end
                last_port = p;
            end
        end
    endtask

    task automatic sample_responses();
        logic [`MUL_PORTS-1:0] rdy;
        for (int p = 0; p < `MUL_PORTS; p++) begin
            if (held[p]) begin
                assert (resp_valid[p]) else begin
                    errors++;
                    $display("Port %0d dropped resp_valid while resp_ready was low", p);
                end
                assert (resp_data[p] == held_data[p]) else begin
                    errors++;
                    $display("Mismatch backpressure_port%0d: expected %h, actual %h", p,
                             held_data[p], resp_data[p]);
                end
            end
        end
        rdy = '1;
        if (stall_en) begin
            for (int p = 0; p < `MUL_PORTS; p++) begin
                if (p == 1 && hold_cnt > 0) rdy[p] = 1'b0; // Long stall on port 1.
                else rdy[p] = !(step_lfsr() & step_lfsr());
            end
            if (hold_cnt > 0) hold_cnt--;
        end
        resp_ready = rdy;
        for (int p = 0; p < `MUL_PORTS; p++) begin
            if (resp_valid[p]) begin
                assert (!req_ready[p]) else begin
                    errors++;
                    $display("Port %0d is ready for a request while holding a response", p);
                end
            end
            held[p]      = resp_valid[p] && !rdy[p];
            held_data[p] = resp_data[p];
            if (resp_valid[p] && rdy[p]) check_resp(p);
        end
        if (resp_valid[0] && rdy[0] && held[1]) overlap++;
    endtask

    task automatic drain();
        while (q0.size() != 0 || q1.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    initial begin
        req_valid   = '0;
        req_a       = '0;
        req_b       = '0;
        resp_ready  = '1;
        for (int p = 0; p < `MUL_PORTS; p++) req_op[p] = rv_mul_pkg::MUL;
        held        = '0;
        held_data   = '0;
        errors      = 0;
        resp_count  = 0;
        overlap     = 0;
        last_port   = -1;
        hold_cnt    = 0;
        stall_en    = 1'b0;
        fair_en     = 1'b0;
        table_ready = 1'b0;
        lfsr        = 32'h5d0892a9;
        build_table();
        table_ready = 1'b1;

        wait (arst_n === 1'b1);
        @(posedge clk);
        #2;
        assert (req_ready == '1 && resp_valid == '0) else begin
            errors++;
            $display("After reset req_ready is %b and resp_valid is %b", req_ready, resp_valid);
        end

        // Corner and early-stop rows, ports alternate, no stalls.
        @(negedge clk);
        fair_en = 1'b1;
        @(posedge clk);
        #2;
        fork
            issue_rows(0, 0, n_first);
            issue_rows(1, 0, n_first);
        join
        drain();

        // Random rows under back-pressure.
        @(negedge clk);
        fair_en  = 1'b0;
        stall_en = 1'b1;
        hold_cnt = HOLD_CYCLES;
        @(posedge clk);
        #2;
        fork
            issue_rows(0, n_first, row_name.size());
            issue_rows(1, n_first, row_name.size());
        join
        drain();
        @(negedge clk);
        stall_en = 1'b0;
        repeat (4) @(posedge clk);

        assert (overlap > 0) else begin
            errors++;
            $display("Port 0 got no results while port 1 was stalled");
        end
        assert (resp_count == row_name.size()) else begin
            errors++;
            $display("Got %0d responses for %0d requests", resp_count, row_name.size());
        end
        $display("Errors: %0d, responses: %0d of %0d", errors, resp_count, row_name.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            #2;
            sample_responses();
        end
    end

    // Watchdog.
    initial begin
        wait (table_ready === 1'b1);
        #((row_name.size() * 70 * `MUL_PORTS + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the unit stopped returning responses");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
rv_mul_pkg.sv
mul_ctrl_pkg.sv
mul_result_format.sv
mul_req_port.sv
mul_arbiter.sv
mul_core.sv
shared_mul_unit.sv
tb_clk_gen.sv
tb_shared_mul_unit.sv

// ==== Bender.yml ====
package:
  name: shared_mul_unit

export_include_dirs:
  - .

sources:
  - rv_mul_pkg.sv
  - mul_ctrl_pkg.sv
  - mul_result_format.sv
  - mul_req_port.sv
  - mul_arbiter.sv
  - mul_core.sv
  - shared_mul_unit.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_shared_mul_unit.sv
